// ==== hdl/rob_pkg.sv ====
package rob_pkg;

  // Payload width of one entry
  localparam int ROB_DATA_WIDTH = 8;

  // Entries that can be in flight at once
  localparam int ROB_DEPTH = 8;

  // Index width follows from the depth
  localparam int ROB_INDEX_WIDTH = $clog2(ROB_DEPTH);

  // Entry index that also serves as the producer's handle
  typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

  // Entry payload
  typedef logic [ROB_DATA_WIDTH-1:0] rob_data_t;

  // Completion request from the out-of-order side
  typedef struct packed {
    logic       enable;
    rob_index_t index;
    rob_data_t  data;
  } rob_write_t;

  // Head of the buffer as seen by the consumer
  typedef struct packed {
    // Head entry reserved and written
    logic      head_ready;
    rob_data_t data;
  } rob_read_t;

  // Registered occupancy flags
  typedef struct packed {
    // All entries reserved
    logic reserve_full;
    // No entry reserved
    logic reserve_empty;
    // All entries written
    logic data_full;
    // No entry written
    logic data_empty;
  } rob_status_t;

endpackage

// ==== hdl/reorder_buffer_controller.sv ====
`timescale 1ns/10ps

module reorder_buffer_controller import rob_pkg::*; (
  input  logic        clock,
  input  logic        resetn,
  // Reservation side
  input  logic        reserve_enable,
  output rob_index_t  reserve_index,
  // Completion side
  input  rob_write_t  write_req,
  output logic        write_error,
  // Consumer side
  input  logic        read_enable,
  output logic        head_ready,
  output rob_status_t status,
  // Entry memory
  output logic        memory_write_enable,
  output rob_index_t  memory_write_address,
  output rob_data_t   memory_write_data,
  output rob_index_t  memory_read_address,
  // Occupancy events
  output logic        reserve_pulse,
  output logic        accept_pulse,
  output logic        read_pulse
);

  // Per-entry state
  logic [ROB_DEPTH-1:0] reserved;
  logic [ROB_DEPTH-1:0] reserved_next;
  logic [ROB_DEPTH-1:0] valid;
  logic [ROB_DEPTH-1:0] valid_next;

  // Pointers carry a wrap bit above the index
  logic [ROB_INDEX_WIDTH:0] reserve_pointer;
  logic [ROB_INDEX_WIDTH:0] reserve_pointer_next;
  logic [ROB_INDEX_WIDTH:0] read_pointer;
  logic [ROB_INDEX_WIDTH:0] read_pointer_next;

  rob_status_t status_next;
  rob_index_t  head_index;
  logic        same_index;
  logic        same_wrap;

  assign head_index    = read_pointer[ROB_INDEX_WIDTH-1:0];
  assign reserve_index = reserve_pointer[ROB_INDEX_WIDTH-1:0];

  // Unreserved target or a second completion to the same entry
  assign write_error = write_req.enable
                    && (!reserved[write_req.index] || valid[write_req.index]);

  // Head is only handed out once its completion arrived
  assign head_ready = valid[head_index];

  // Next state of pointers and entry bits
  always_comb begin
    reserve_pointer_next = reserve_pointer;
    read_pointer_next    = read_pointer;
    reserved_next        = reserved;
    valid_next           = valid;
    // Reserve the entry under the reservation pointer
    if (reserve_enable) begin
      reserved_next[reserve_index] = 1'b1;
      reserve_pointer_next         = reserve_pointer + 1'b1;
    end
    // Only an accepted completion marks its entry valid
    if (write_req.enable && !write_error) begin
      valid_next[write_req.index] = 1'b1;
    end
    // Pop releases both bits of the head
    if (read_enable) begin
      valid_next[head_index]    = 1'b0;
      reserved_next[head_index] = 1'b0;
      read_pointer_next         = read_pointer + 1'b1;
    end
  end

  // Flags describe the state after this edge
  assign same_index = reserve_pointer_next[ROB_INDEX_WIDTH-1:0]
                   == read_pointer_next[ROB_INDEX_WIDTH-1:0];
  assign same_wrap  = reserve_pointer_next[ROB_INDEX_WIDTH]
                   == read_pointer_next[ROB_INDEX_WIDTH];

  always_comb begin
    status_next.reserve_full  = same_index && !same_wrap;
    status_next.reserve_empty = same_index && same_wrap;
    status_next.data_full     = &valid_next;
    status_next.data_empty    = ~|valid_next;
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserve_pointer <= '0;
      read_pointer    <= '0;
      reserved        <= '0;
      valid           <= '0;
      status          <= '{reserve_full: 1'b0, reserve_empty: 1'b1,
                           data_full: 1'b0, data_empty: 1'b1};
    end else begin
      reserve_pointer <= reserve_pointer_next;
      read_pointer    <= read_pointer_next;
      reserved        <= reserved_next;
      valid           <= valid_next;
      status          <= status_next;
    end
  end

  // Every request reaches the memory, even a rejected one
  assign memory_write_enable  = write_req.enable;
  assign memory_write_address = write_req.index;
  assign memory_write_data    = write_req.data;
  assign memory_read_address  = head_index;

  // Events for the occupancy counters
  assign reserve_pulse = reserve_enable;
  assign accept_pulse  = write_req.enable && !write_error;
  assign read_pulse    = read_enable;

  // Producer must stop at the registered full flag
  reserve_in_room: assert property (@(posedge clock) disable iff (!resetn)
    reserve_enable |-> !status.reserve_full);

  // Consumer may only pop a written head
  read_when_ready: assert property (@(posedge clock) disable iff (!resetn)
    read_enable |-> head_ready);

endmodule

// ==== hdl/rob_entry_memory.sv ====
`timescale 1ns/10ps

module rob_entry_memory import rob_pkg::*; (
  input  logic       clock,
  // Write port
  input  logic       write_enable,
  input  rob_index_t write_address,
  input  rob_data_t  write_data,
  // Read port at the head of the buffer
  input  rob_index_t read_address,
  output rob_data_t  read_data
);

  // One payload register per entry
  rob_data_t entries [ROB_DEPTH];

  // Completion data lands at the edge
  always_ff @(posedge clock) begin
    if (write_enable) begin
      entries[write_address] <= write_data;
    end
  end

  // Head data is available in the same cycle
  assign read_data = entries[read_address];

endmodule

// ==== hdl/rob_occupancy.sv ====
`timescale 1ns/10ps

module rob_occupancy import rob_pkg::*; (
  input  logic                   clock,
  input  logic                   resetn,
  // Single-cycle events from the controller
  input  logic                   reserve_pulse,
  input  logic                   accept_pulse,
  input  logic                   read_pulse,
  // One extra bit so a full buffer fits
  output logic [ROB_INDEX_WIDTH:0] reserved_count,
  output logic [ROB_INDEX_WIDTH:0] pending_count
);

  logic [ROB_INDEX_WIDTH:0] reserved_count_next;
  logic [ROB_INDEX_WIDTH:0] pending_count_next;

  // Reserved and not yet read
  always_comb begin
    reserved_count_next = reserved_count;
    if (reserve_pulse && !read_pulse) begin
      reserved_count_next = reserved_count + 1'b1;
    end else if (read_pulse && !reserve_pulse) begin
      reserved_count_next = reserved_count - 1'b1;
    end
  end

  // Written and not yet read
  always_comb begin
    pending_count_next = pending_count;
    if (accept_pulse && !read_pulse) begin
      pending_count_next = pending_count + 1'b1;
    end else if (read_pulse && !accept_pulse) begin
      pending_count_next = pending_count - 1'b1;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserved_count <= '0;
      pending_count  <= '0;
    end else begin
      reserved_count <= reserved_count_next;
      pending_count  <= pending_count_next;
    end
  end

  // Written entries are a subset of reserved ones, which never exceed the depth
  counts_in_bounds: assert property (@(posedge clock) disable iff (!resetn)
    pending_count <= reserved_count && reserved_count <= ROB_DEPTH);

endmodule

// ==== hdl/rob_error_log.sv ====
`timescale 1ns/10ps

module rob_error_log import rob_pkg::*; #(
  parameter int ERROR_COUNT_WIDTH = 4
) (
  input  logic                         clock,
  input  logic                         resetn,
  // Rejected completion and its target
  input  logic                         write_error,
  input  rob_index_t                   error_index,
  // Log outputs
  output logic [ERROR_COUNT_WIDTH-1:0] error_count,
  output rob_index_t                   last_error_index
);

  logic count_at_max;

  // Counter sticks once all ones
  assign count_at_max = &error_count;

  // Count of rejected writes
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      error_count <= '0;
    end else if (write_error && !count_at_max) begin
      error_count <= error_count + 1'b1;
    end
  end

  // Index of the most recent offender
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      last_error_index <= '0;
    end else if (write_error) begin
      last_error_index <= error_index;
    end
  end

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer import rob_pkg::*; #(
  parameter int ERROR_COUNT_WIDTH = 4
) (
  input  logic                         clock,
  input  logic                         resetn,
  // Reservation side
  input  logic                         reserve_enable,
  output rob_index_t                   reserve_index,
  // Completion side
  input  rob_write_t                   write_req,
  output logic                         write_error,
  // Consumer side
  input  logic                         read_enable,
  output rob_read_t                    read_out,
  output rob_status_t                  status,
  // Occupancy
  output logic [ROB_INDEX_WIDTH:0]     reserved_count,
  output logic [ROB_INDEX_WIDTH:0]     pending_count,
  // Error log
  output logic [ERROR_COUNT_WIDTH-1:0] error_count,
  output rob_index_t                   last_error_index
);

  // Memory wiring
  logic       memory_write_enable;
  rob_index_t memory_write_address;
  rob_data_t  memory_write_data;
  rob_index_t memory_read_address;

  // Occupancy events
  logic reserve_pulse;
  logic accept_pulse;
  logic read_pulse;

  reorder_buffer_controller controller (
    .clock                (clock),
    .resetn               (resetn),
    .reserve_enable       (reserve_enable),
    .reserve_index        (reserve_index),
    .write_req            (write_req),
    .write_error          (write_error),
    .read_enable          (read_enable),
    .head_ready           (read_out.head_ready),
    .status               (status),
    .memory_write_enable  (memory_write_enable),
    .memory_write_address (memory_write_address),
    .memory_write_data    (memory_write_data),
    .memory_read_address  (memory_read_address),
    .reserve_pulse        (reserve_pulse),
    .accept_pulse         (accept_pulse),
    .read_pulse           (read_pulse)
  );

  // Head data goes straight to the consumer
  rob_entry_memory memory (
    .clock         (clock),
    .write_enable  (memory_write_enable),
    .write_address (memory_write_address),
    .write_data    (memory_write_data),
    .read_address  (memory_read_address),
    .read_data     (read_out.data)
  );

  rob_occupancy occupancy (
    .clock          (clock),
    .resetn         (resetn),
    .reserve_pulse  (reserve_pulse),
    .accept_pulse   (accept_pulse),
    .read_pulse     (read_pulse),
    .reserved_count (reserved_count),
    .pending_count  (pending_count)
  );

  // Offending index is the one on the request
  rob_error_log #(
    .ERROR_COUNT_WIDTH (ERROR_COUNT_WIDTH)
  ) error_log (
    .clock            (clock),
    .resetn           (resetn),
    .write_error      (write_error),
    .error_index      (write_req.index),
    .error_count      (error_count),
    .last_error_index (last_error_index)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic resetn
);

  // Free-running clock
  initial begin
    clock = 1'b0;
  end

  always #(PERIOD / 2) clock = ~clock;

  // Reset held for a fixed number of cycles, released away from the rising edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
  end

endmodule

// ==== tests/reorder_buffer_checker.sv ====
`timescale 1ns/10ps

module reorder_buffer_checker import rob_pkg::*; #(
  parameter int ERROR_COUNT_WIDTH = 4
) (
  input  logic                         clock,
  input  logic                         resetn,
  // DUT inputs
  input  logic                         reserve_enable,
  input  rob_write_t                   write_req,
  input  logic                         read_enable,
  // Write error that the stimulus row expects
  input  logic                         table_error,
  // DUT outputs
  input  rob_index_t                   reserve_index,
  input  logic                         write_error,
  input  rob_read_t                    read_out,
  input  rob_status_t                  status,
  input  logic [ROB_INDEX_WIDTH:0]     reserved_count,
  input  logic [ROB_INDEX_WIDTH:0]     pending_count,
  input  logic [ERROR_COUNT_WIDTH-1:0] error_count,
  input  rob_index_t                   last_error_index,
  // Results
  output int                           mismatch_count,
  output int                           checked_cycles
);

  // Reference state
  logic [ROB_DEPTH-1:0]         reserved_model;
  logic [ROB_DEPTH-1:0]         valid_model;
  rob_data_t                    data_model [ROB_DEPTH];
  int unsigned                  reserve_ptr_model;
  int unsigned                  read_ptr_model;
  rob_status_t                  status_model;
  logic [ERROR_COUNT_WIDTH-1:0] error_count_model;
  rob_index_t                   last_error_model;

  // Per-cycle temporaries
  rob_index_t head;
  rob_index_t slot;
  logic       expected_error;

  initial begin
    mismatch_count = 0;
    checked_cycles = 0;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s at %0t: actual %0h expected %0h", name, $time, actual, expected);
    end
  endtask

  // Compare before the edge, then advance the model
  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserved_model    = '0;
      valid_model       = '0;
      reserve_ptr_model = 0;
      read_ptr_model    = 0;
      status_model      = '{reserve_full: 1'b0, reserve_empty: 1'b1,
                            data_full: 1'b0, data_empty: 1'b1};
      error_count_model = '0;
      last_error_model  = '0;
    end else begin
      checked_cycles++;
      head = rob_index_t'(read_ptr_model);
      slot = write_req.index;
      // Rejected if the slot was never reserved or already holds data
      expected_error = write_req.enable && (!reserved_model[slot] || valid_model[slot]);
      check_value("reserve_index", reserve_index, rob_index_t'(reserve_ptr_model));
      check_value("write_error", write_error, expected_error);
      check_value("write_error (table)", write_error, table_error);
      check_value("read_out.head_ready", read_out.head_ready, valid_model[head]);
      // Payload only defined once written
      if (valid_model[head]) begin
        check_value("read_out.data", read_out.data, data_model[head]);
      end
      check_value("status", status, status_model);
      check_value("reserved_count", reserved_count, $countones(reserved_model));
      check_value("pending_count", pending_count, $countones(valid_model));
      check_value("error_count", error_count, error_count_model);
      check_value("last_error_index", last_error_index, last_error_model);
      if (reserve_enable) begin
        reserved_model[rob_index_t'(reserve_ptr_model)] = 1'b1;
        reserve_ptr_model++;
      end
      // Data lands even on a rejected write
      if (write_req.enable) begin
        data_model[slot] = write_req.data;
        if (!expected_error) begin
          valid_model[slot] = 1'b1;
        end
      end
      if (expected_error) begin
        if (error_count_model != '1) begin
          error_count_model++;
        end
        last_error_model = slot;
      end
      if (read_enable) begin
        reserved_model[head] = 1'b0;
        valid_model[head]    = 1'b0;
        read_ptr_model++;
      end
      // Flags follow the state after this edge
      status_model.reserve_full  = $countones(reserved_model) == ROB_DEPTH;
      status_model.reserve_empty = $countones(reserved_model) == 0;
      status_model.data_full     = $countones(valid_model) == ROB_DEPTH;
      status_model.data_empty    = $countones(valid_model) == 0;
    end
  end

endmodule

// ==== tests/reorder_buffer_tb.sv ====
`timescale 1ns/10ps

module reorder_buffer_tb import rob_pkg::*; ();

  localparam int          CLOCK_PERIOD      = 40;
  localparam int          RESET_CYCLES      = 10;
  localparam int          ERROR_COUNT_WIDTH = 4;
  localparam int          TABLE_LENGTH      = 30;
  localparam int unsigned RANDOM_SEED       = 32'h58b46e6d;

  // One stimulus row, applied for one cycle
  typedef struct packed {
    logic       reserve;
    logic       write;
    // Target is a raw index instead of an offset back from the reserve pointer
    logic       absolute;
    logic [3:0] target;
    logic       read;
    logic       error;
  } op_t;

  logic                         clock;
  logic                         resetn;
  logic                         reserve_enable;
  rob_write_t                   write_req;
  logic                         read_enable;
  logic                         row_error;
  rob_index_t                   reserve_index;
  logic                         write_error;
  rob_read_t                    read_out;
  rob_status_t                  status;
  logic [ROB_INDEX_WIDTH:0]     reserved_count;
  logic [ROB_INDEX_WIDTH:0]     pending_count;
  logic [ERROR_COUNT_WIDTH-1:0] error_count;
  rob_index_t                   last_error_index;
  int                           mismatch_count;
  int                           checked_cycles;
  int                           table_errors;
  op_t                          ops [$];

  tb_clock_gen #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
    .clock  (clock),
    .resetn (resetn)
  );

  reorder_buffer #(.ERROR_COUNT_WIDTH(ERROR_COUNT_WIDTH)) uut (
    .clock            (clock),
    .resetn           (resetn),
    .reserve_enable   (reserve_enable),
    .reserve_index    (reserve_index),
    .write_req        (write_req),
    .write_error      (write_error),
    .read_enable      (read_enable),
    .read_out         (read_out),
    .status           (status),
    .reserved_count   (reserved_count),
    .pending_count    (pending_count),
    .error_count      (error_count),
    .last_error_index (last_error_index)
  );

  reorder_buffer_checker #(.ERROR_COUNT_WIDTH(ERROR_COUNT_WIDTH)) monitor (
    .clock            (clock),
    .resetn           (resetn),
    .reserve_enable   (reserve_enable),
    .write_req        (write_req),
    .read_enable      (read_enable),
    .table_error      (row_error),
    .reserve_index    (reserve_index),
    .write_error      (write_error),
    .read_out         (read_out),
    .status           (status),
    .reserved_count   (reserved_count),
    .pending_count    (pending_count),
    .error_count      (error_count),
    .last_error_index (last_error_index),
    .mismatch_count   (mismatch_count),
    .checked_cycles   (checked_cycles)
  );

  function automatic op_t make_op(input logic reserve, input logic write, input logic absolute,
                                  input logic [3:0] target, input logic read, input logic error);
    op_t op;
    op = '{reserve, write, absolute, target, read, error};
    return op;
  endfunction

  task automatic build_table();
    // Idle row shows the reset state
    ops.push_back(make_op(0, 0, 0, 0, 0, 0));
    // Reserve all eight entries
    repeat (ROB_DEPTH) ops.push_back(make_op(1, 0, 0, 0, 0, 0));
    // Scrambled completions; entry 0 arrives fifth
    ops.push_back(make_op(0, 1, 0, 5, 0, 0));
    ops.push_back(make_op(0, 1, 0, 1, 0, 0));
    ops.push_back(make_op(0, 1, 0, 5, 0, 1));
    ops.push_back(make_op(0, 1, 0, 2, 0, 0));
    ops.push_back(make_op(0, 1, 0, 8, 0, 0));
    ops.push_back(make_op(0, 1, 0, 4, 0, 0));
    ops.push_back(make_op(0, 1, 0, 7, 0, 0));
    ops.push_back(make_op(0, 1, 0, 3, 0, 0));
    ops.push_back(make_op(0, 1, 0, 6, 0, 0));
    // Drain in order while new reservations wrap the pointer
    ops.push_back(make_op(0, 0, 0, 0, 1, 0));
    ops.push_back(make_op(1, 0, 0, 0, 1, 0));
    // Entry 1 was popped on the previous edge
    ops.push_back(make_op(1, 1, 1, 1, 1, 1));
    ops.push_back(make_op(0, 1, 0, 2, 1, 0));
    ops.push_back(make_op(0, 0, 0, 0, 1, 0));
    ops.push_back(make_op(0, 1, 0, 1, 1, 0));
    repeat (4) ops.push_back(make_op(0, 0, 0, 0, 1, 0));
    // Completion into an empty buffer
    ops.push_back(make_op(0, 1, 1, 5, 0, 1));
    ops.push_back(make_op(0, 0, 0, 0, 0, 0));
  endtask

  initial begin
    int unsigned          issued;
    int unsigned          head;
    logic [ROB_DEPTH-1:0] written;
    rob_index_t           target_index;
    op_t                  op;
    reserve_enable = 1'b0;
    write_req      = '0;
    read_enable    = 1'b0;
    row_error      = 1'b0;
    table_errors   = 0;
    issued         = 0;
    head           = 0;
    written        = '0;
    void'($urandom(RANDOM_SEED));
    build_table();
    if (ops.size() != TABLE_LENGTH) begin
      table_errors++;
      $display("Stimulus table has %0d rows instead of %0d", ops.size(), TABLE_LENGTH);
    end
    wait (resetn === 1'b1);
    @(negedge clock);
    foreach (ops[row]) begin
      op = ops[row];
      if (op.absolute) begin
        target_index = op.target[ROB_INDEX_WIDTH-1:0];
      end else begin
        target_index = rob_index_t'(issued - op.target);
      end
      // A pop is legal only once the head entry has been written
      if (op.read && !written[rob_index_t'(head)]) begin
        table_errors++;
        $display("Table row %0d pops a head entry that was never written", row);
      end
      reserve_enable  = op.reserve;
      write_req.enable = op.write;
      write_req.index = target_index;
      write_req.data  = rob_data_t'($urandom);
      read_enable     = op.read;
      row_error       = op.error;
      if (op.write && !op.error) begin
        written[target_index] = 1'b1;
      end
      if (op.read) begin
        written[rob_index_t'(head)] = 1'b0;
        head++;
      end
      if (op.reserve) begin
        issued++;
      end
      @(negedge clock);
    end
    reserve_enable = 1'b0;
    write_req      = '0;
    read_enable    = 1'b0;
    row_error      = 1'b0;
    @(negedge clock);
    $display("Closing: %0d cycles checked, %0d mismatches, %0d table errors",
             checked_cycles, mismatch_count, table_errors);
    if (mismatch_count == 0 && table_errors == 0 && checked_cycles > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin
    #((TABLE_LENGTH + RESET_CYCLES) * CLOCK_PERIOD * 2);
    $display("Watchdog expired: the stimulus loop did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
hdl/rob_pkg.sv
hdl/reorder_buffer_controller.sv
hdl/rob_entry_memory.sv
hdl/rob_occupancy.sv
hdl/rob_error_log.sv
hdl/reorder_buffer.sv
tests/tb_clock_gen.sv
tests/reorder_buffer_checker.sv
tests/reorder_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: reorder_buffer

sources:
  - files:
      - hdl/rob_pkg.sv
      - hdl/reorder_buffer_controller.sv
      - hdl/rob_entry_memory.sv
      - hdl/rob_occupancy.sv
      - hdl/rob_error_log.sv
      - hdl/reorder_buffer.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/reorder_buffer_checker.sv
      - tests/reorder_buffer_tb.sv
